//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        := mem_controller_tb
RTL_TOP    := mem_controller
FILELIST   := src.f
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(shell cat $(FILELIST)) hdl/boot_rom.hex
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qx "all tests passed" $(LOG) || { echo "simulation incomplete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/boot_rom.hex
// boot ROM image, one 32-bit word per line in hex, word 0 first
3C08BFC0
35080100
8D090000
00000000
3C0A1F80
AD490000
240B0010
256BFFFF
1560FFFE
00000000
3C0C8000
01800008
00000000
0BF00000
00000000
1BADB002

//--- hdl/boot_rom.sv
/*
 * boot_rom
 * sixteen-word boot table with registered read, filled from a hex file
 */
module boot_rom (
   input  logic           clk,
   input  logic           en_i,
   input  logic [3:0]     idx_i,
   output bus_pkg::word_t rdata_o
);

   bus_pkg::word_t rom [16];

   initial begin
      $readmemh("hdl/boot_rom.hex", rom);
   end

   always_ff @(posedge clk) begin
      if (en_i)
         rdata_o <= rom[idx_i];
   end

endmodule

//--- hdl/bus_pkg.sv
/*
 * bus_pkg
 * widths, word and byte-enable types, port ids and arbiter states of the memory bus
 */
package bus_pkg;

   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int ben_w  = 4;   // one enable per byte lane

   typedef logic [data_w-1:0] word_t;
   typedef logic [ben_w-1:0]  ben_t;

   // owner of the access in flight
   typedef enum logic {
      PORT_DATA,
      PORT_INST
   } port_e;

   // request arbitration states
   typedef enum logic [1:0] {
      IDLE,       // waiting for a port request
      ISSUE,      // access presented to the decoder
      WAIT_MEM,   // waiting for the decoder ack
      HOLD        // port ack high until the request drops
   } arb_state_e;

endpackage

//--- hdl/mem_controller.sv
/*
 * mem_controller
 * memory side of the cpu core: port arbiter, address decoder, RAMs and boot ROM
 */
module mem_controller (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [bus_pkg::addr_w-1:0] data_addr_i,
   input  bus_pkg::word_t             data_wdata_i,
   input  logic                       data_ren_i,
   input  bus_pkg::ben_t              data_wen_i,
   output logic                       data_ack_o,
   output bus_pkg::word_t             data_rdata_o,
   input  logic [bus_pkg::addr_w-1:0] inst_addr_i,
   input  logic                       inst_ren_i,
   output logic                       inst_ack_o,
   output bus_pkg::word_t             inst_rdata_o
);

   logic                                          main_en, main_we;
   logic [$clog2(mem_map_pkg::main_words)-1:0]    main_idx;
   bus_pkg::ben_t                                 main_ben;
   bus_pkg::word_t                                main_wdata, main_rdata;

   logic                                          scr_en, scr_we;
   logic [$clog2(mem_map_pkg::scratch_words)-1:0] scr_idx;
   bus_pkg::ben_t                                 scr_ben;
   bus_pkg::word_t                                scr_wdata, scr_rdata;

   logic                                          rom_en;
   logic [$clog2(mem_map_pkg::rom_words)-1:0]     rom_idx;
   bus_pkg::word_t                                rom_rdata;

   mem_req_if mem_bus ();

   port_arbiter arbiter (
      .clk, .rst,
      .data_addr_i, .data_wdata_i, .data_ren_i, .data_wen_i, .data_ack_o, .data_rdata_o,
      .inst_addr_i, .inst_ren_i, .inst_ack_o, .inst_rdata_o,
      .mem          (mem_bus)
   );

   region_decoder decoder (
      .clk, .rst,
      .mem          (mem_bus),
      .main_en_o    (main_en),   .main_we_o    (main_we),   .main_idx_o  (main_idx),
      .main_ben_o   (main_ben),  .main_wdata_o (main_wdata), .main_rdata_i (main_rdata),
      .scr_en_o     (scr_en),    .scr_we_o     (scr_we),    .scr_idx_o   (scr_idx),
      .scr_ben_o    (scr_ben),   .scr_wdata_o  (scr_wdata), .scr_rdata_i (scr_rdata),
      .rom_en_o     (rom_en),    .rom_idx_o    (rom_idx),   .rom_rdata_i (rom_rdata)
   );

   // stands in for the SDRAM
   word_ram #(.depth(mem_map_pkg::main_words)) main_ram (
      .clk, .en_i(main_en), .we_i(main_we), .idx_i(main_idx),
      .ben_i(main_ben), .wdata_i(main_wdata), .rdata_o(main_rdata)
   );

   word_ram #(.depth(mem_map_pkg::scratch_words)) scratch_ram (
      .clk, .en_i(scr_en), .we_i(scr_we), .idx_i(scr_idx),
      .ben_i(scr_ben), .wdata_i(scr_wdata), .rdata_o(scr_rdata)
   );

   boot_rom bios (
      .clk, .en_i(rom_en), .idx_i(rom_idx), .rdata_o(rom_rdata)
   );

endmodule

//--- hdl/mem_map_pkg.sv
/*
 * mem_map_pkg
 * physical address map of the console: region bases, sizes and the segment mask
 */
package mem_map_pkg;

   // kuseg, kseg0 and kseg1 all mirror the same physical space
   localparam logic [bus_pkg::addr_w-1:0] seg_mask = 32'h1FFF_FFFF;

   localparam logic [bus_pkg::addr_w-1:0] main_base = 32'h0000_0000;
   localparam int unsigned main_words = 1024;   // 4 KiB

   localparam logic [bus_pkg::addr_w-1:0] scratch_base = 32'h1F80_0000;
   localparam int unsigned scratch_words = 256;   // 1 KiB

   localparam logic [bus_pkg::addr_w-1:0] rom_base = 32'h1FC0_0000;
   localparam int unsigned rom_words = 16;

   // decoded target of one access
   typedef enum logic [1:0] {
      REG_MAIN,
      REG_SCRATCH,
      REG_ROM,
      REG_NONE   // unmapped, reads give zero
   } region_e;

endpackage

//--- hdl/mem_req_if.sv
/*
 * mem_req_if
 * one granted word access from the arbiter to the decoder and its response
 */
interface mem_req_if;

   logic                        valid;   // one cycle per access
   logic [bus_pkg::addr_w-1:0]  addr;
   bus_pkg::word_t              wdata;
   bus_pkg::ben_t               ben;
   logic                        write;

   logic                        ack;     // one cycle, two edges after valid
   bus_pkg::word_t              rdata;

   modport arbiter (
      output valid, addr, wdata, ben, write,
      input  ack, rdata
   );

   modport decoder (
      input  valid, addr, wdata, ben, write,
      output ack, rdata
   );

endinterface

//--- hdl/port_arbiter.sv
/*
 * port_arbiter
 * grants data or instruction requests one at a time, data first, and runs each port's ack
 */
module port_arbiter (
   input  logic                       clk,
   input  logic                       rst,
   // cpu data port
   input  logic [bus_pkg::addr_w-1:0] data_addr_i,
   input  bus_pkg::word_t             data_wdata_i,
   input  logic                       data_ren_i,
   input  bus_pkg::ben_t              data_wen_i,
   output logic                       data_ack_o,
   output bus_pkg::word_t             data_rdata_o,
   // cpu instruction port
   input  logic [bus_pkg::addr_w-1:0] inst_addr_i,
   input  logic                       inst_ren_i,
   output logic                       inst_ack_o,
   output bus_pkg::word_t             inst_rdata_o,
   // granted access towards the decoder
   mem_req_if.arbiter                 mem
);

   bus_pkg::arb_state_e state_q;
   bus_pkg::port_e      owner_q;
   logic                data_active;
   logic                owner_req;

   assign data_active = data_ren_i || (|data_wen_i);
   assign owner_req   = (owner_q == bus_pkg::PORT_DATA) ? data_active : inst_ren_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q      <= bus_pkg::IDLE;
         owner_q      <= bus_pkg::PORT_DATA;
         mem.valid    <= 1'b0;
         data_ack_o   <= 1'b0;
         inst_ack_o   <= 1'b0;
         data_rdata_o <= '0;
         inst_rdata_o <= '0;
      end else begin
         case (state_q)
            bus_pkg::IDLE: begin
               if (data_active) begin   // data port has priority
                  owner_q   <= bus_pkg::PORT_DATA;
                  mem.valid <= 1'b1;
                  state_q   <= bus_pkg::ISSUE;
               end else if (inst_ren_i) begin
                  owner_q   <= bus_pkg::PORT_INST;
                  mem.valid <= 1'b1;
                  state_q   <= bus_pkg::ISSUE;
               end
            end
            bus_pkg::ISSUE: begin
               mem.valid <= 1'b0;
               state_q   <= bus_pkg::WAIT_MEM;
            end
            bus_pkg::WAIT_MEM: begin
               if (mem.ack) begin
                  state_q <= bus_pkg::HOLD;
                  if (owner_q == bus_pkg::PORT_DATA) begin
                     data_ack_o <= 1'b1;
                     if (!mem.write)
                        data_rdata_o <= mem.rdata;   // writes keep the last read
                  end else begin
                     inst_ack_o   <= 1'b1;
                     inst_rdata_o <= mem.rdata;
                  end
               end
            end
            bus_pkg::HOLD: begin
               // four-phase release, ack drops once the request is gone
               if (!owner_req) begin
                  data_ack_o <= 1'b0;
                  inst_ack_o <= 1'b0;
                  state_q    <= bus_pkg::IDLE;
               end
            end
            default: state_q <= bus_pkg::IDLE;
         endcase
      end
   end

   // request capture, held stable from ISSUE until the next grant
   always_ff @(posedge clk) begin
      if (state_q == bus_pkg::IDLE) begin
         if (data_active) begin
            mem.addr  <= data_addr_i;
            mem.wdata <= data_wdata_i;
            mem.write <= !data_ren_i;                  // read wins over write
            mem.ben   <= data_ren_i ? '1 : data_wen_i; // reads use all lanes
         end else begin
            mem.addr  <= inst_addr_i;
            mem.write <= 1'b0;
            mem.ben   <= '1;
         end
      end
   end

   // a requester holds its request until the ack rises
   a_req_held: assert property (@(posedge clk) disable iff (rst)
      (state_q == bus_pkg::ISSUE || state_q == bus_pkg::WAIT_MEM) |-> owner_req);

   // the decoder only answers the access in flight
   a_ack_in_wait: assert property (@(posedge clk) disable iff (rst)
      mem.ack |-> (state_q == bus_pkg::WAIT_MEM));

endmodule

//--- hdl/region_decoder.sv
/*
 * region_decoder
 * maps a granted access onto main RAM, scratchpad or boot ROM and returns its ack
 */
module region_decoder (
   input  logic                                           clk,
   input  logic                                           rst,
   mem_req_if.decoder                                     mem,
   // main RAM
   output logic                                           main_en_o,
   output logic                                           main_we_o,
   output logic [$clog2(mem_map_pkg::main_words)-1:0]     main_idx_o,
   output bus_pkg::ben_t                                  main_ben_o,
   output bus_pkg::word_t                                 main_wdata_o,
   input  bus_pkg::word_t                                 main_rdata_i,
   // scratchpad
   output logic                                           scr_en_o,
   output logic                                           scr_we_o,
   output logic [$clog2(mem_map_pkg::scratch_words)-1:0]  scr_idx_o,
   output bus_pkg::ben_t                                  scr_ben_o,
   output bus_pkg::word_t                                 scr_wdata_o,
   input  bus_pkg::word_t                                 scr_rdata_i,
   // boot ROM
   output logic                                           rom_en_o,
   output logic [$clog2(mem_map_pkg::rom_words)-1:0]      rom_idx_o,
   input  bus_pkg::word_t                                 rom_rdata_i
);

   logic [bus_pkg::addr_w-1:0] phys;
   mem_map_pkg::region_e       region;
   mem_map_pkg::region_e       region_q;
   logic                       pend_q;   // memory read in progress
   bus_pkg::word_t             rd_sel;

   assign phys = mem.addr & mem_map_pkg::seg_mask;

   // offset compare, wraps high when below a base
   always_comb begin
      if (phys - mem_map_pkg::main_base < 4 * mem_map_pkg::main_words)
         region = mem_map_pkg::REG_MAIN;
      else if (phys - mem_map_pkg::scratch_base < 4 * mem_map_pkg::scratch_words)
         region = mem_map_pkg::REG_SCRATCH;
      else if (phys - mem_map_pkg::rom_base < 4 * mem_map_pkg::rom_words)
         region = mem_map_pkg::REG_ROM;
      else
         region = mem_map_pkg::REG_NONE;
   end

   // bases are aligned, so the low address bits are the word index
   assign main_en_o    = mem.valid && (region == mem_map_pkg::REG_MAIN);
   assign main_we_o    = mem.write;
   assign main_idx_o   = phys[2 +: $clog2(mem_map_pkg::main_words)];
   assign main_ben_o   = mem.ben;
   assign main_wdata_o = mem.wdata;

   assign scr_en_o     = mem.valid && (region == mem_map_pkg::REG_SCRATCH);
   assign scr_we_o     = mem.write;
   assign scr_idx_o    = phys[2 +: $clog2(mem_map_pkg::scratch_words)];
   assign scr_ben_o    = mem.ben;
   assign scr_wdata_o  = mem.wdata;

   assign rom_en_o     = mem.valid && !mem.write && (region == mem_map_pkg::REG_ROM);
   assign rom_idx_o    = phys[2 +: $clog2(mem_map_pkg::rom_words)];

   always_comb begin
      case (region_q)
         mem_map_pkg::REG_MAIN:    rd_sel = main_rdata_i;
         mem_map_pkg::REG_SCRATCH: rd_sel = scr_rdata_i;
         mem_map_pkg::REG_ROM:     rd_sel = rom_rdata_i;
         default:                  rd_sel = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend_q   <= 1'b0;
         region_q <= mem_map_pkg::REG_NONE;
         mem.ack  <= 1'b0;
      end else begin
         pend_q  <= mem.valid;
         mem.ack <= pend_q;
         if (mem.valid)
            region_q <= region;
      end
   end

   always_ff @(posedge clk) begin
      if (pend_q)
         mem.rdata <= rd_sel;   // zero for unmapped
   end

   // no new access while one is still in flight
   a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
      mem.valid |-> (!pend_q && !mem.ack));

endmodule

//--- hdl/word_ram.sv
/*
 * word_ram
 * single-port word RAM with per-byte write enables and registered read
 */
module word_ram #(
   parameter int unsigned depth = 1024   // words, power of two
) (
   input  logic                     clk,
   input  logic                     en_i,
   input  logic                     we_i,
   input  logic [$clog2(depth)-1:0] idx_i,
   input  bus_pkg::ben_t            ben_i,
   input  bus_pkg::word_t           wdata_i,
   output bus_pkg::word_t           rdata_o
);

   bus_pkg::word_t mem [depth];

   always_ff @(posedge clk) begin
      if (en_i) begin
         if (we_i) begin
            for (int b = 0; b < bus_pkg::ben_w; b++) begin
               if (ben_i[b])
                  mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
         rdata_o <= mem[idx_i];   // old word on a write
      end
   end

endmodule

//--- src.f
hdl/bus_pkg.sv
hdl/mem_map_pkg.sv
hdl/mem_req_if.sv
hdl/word_ram.sv
hdl/boot_rom.sv
hdl/port_arbiter.sv
hdl/region_decoder.sv
hdl/mem_controller.sv
tests/clock_gen.sv
tests/mem_controller_tb.sv

//--- tests/clock_gen.sv
/*
 * clock_gen
 * testbench clock and active-high reset for the first cycles
 */
module clock_gen #(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 4
) (
   output logic clk_o,
   output logic rst_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(period_ns / 2) clk_o = ~clk_o;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      rst_o = 1'b1;
      #(reset_cycles * period_ns) rst_o = 1'b0;
   end

endmodule

//--- tests/mem_controller_tb.sv
/*
 * mem_controller_tb
 * table-driven accesses on both cpu ports, checked against a model of the memory map
 */
module mem_controller_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int period_ns   = 100;
   localparam int req_to_ack  = 3;   // cycles from the sampling edge to the ack
   localparam int fill_words  = 4;   // random words per RAM before the table
   localparam int n_steps     = 19;
   localparam int n_access    = n_steps + 2 * fill_words + 2;
   localparam int timeout_cyc = n_access * 20;

   typedef struct packed {
      logic           inst;         // instruction port, else data port
      logic           wr;
      logic [31:0]    addr;
      bus_pkg::ben_t  ben;
      bus_pkg::word_t wdata;
      logic           from_model;   // expected word comes from the model
      bus_pkg::word_t exp;
   } step_t;

   step_t steps [n_steps] = '{
      '{1'b1, 1'b0, 32'h1FC0_0000, 4'hF, 32'h0, 1'b1, 32'h0},          // rom, physical
      '{1'b1, 1'b0, 32'hBFC0_0000, 4'hF, 32'h0, 1'b1, 32'h0},          // rom via kseg1
      '{1'b1, 1'b0, 32'h9FC0_003C, 4'hF, 32'h0, 1'b1, 32'h0},          // last word via kseg0
      '{1'b0, 1'b0, 32'hBFC0_0014, 4'hF, 32'h0, 1'b1, 32'h0},
      '{1'b0, 1'b1, 32'h0000_0010, 4'hF, 32'hCAFE_0001, 1'b0, 32'h0},
      '{1'b0, 1'b0, 32'h8000_0010, 4'hF, 32'h0, 1'b0, 32'hCAFE_0001},
      '{1'b0, 1'b1, 32'h0000_0FFC, 4'hF, 32'h1234_5678, 1'b0, 32'h0},  // top of main RAM
      '{1'b1, 1'b0, 32'hA000_0FFC, 4'hF, 32'h0, 1'b0, 32'h1234_5678},
      '{1'b0, 1'b0, 32'h0000_0008, 4'hF, 32'h0, 1'b1, 32'h0},          // random fill word
      '{1'b0, 1'b1, 32'h1F80_0004, 4'h3, 32'hAAAA_BBBB, 1'b0, 32'h0},
      '{1'b0, 1'b0, 32'h1F80_0004, 4'hF, 32'h0, 1'b1, 32'h0},
      '{1'b0, 1'b1, 32'h9F80_0008, 4'h8, 32'h5500_0000, 1'b0, 32'h0},
      '{1'b0, 1'b1, 32'h1F80_0008, 4'h6, 32'h0012_3400, 1'b0, 32'h0},
      '{1'b0, 1'b0, 32'h1F80_0008, 4'hF, 32'h0, 1'b1, 32'h0},
      '{1'b0, 1'b1, 32'h1FC0_0008, 4'hF, 32'hDEAD_BEEF, 1'b0, 32'h0},  // write to rom
      '{1'b1, 1'b0, 32'hBFC0_0008, 4'hF, 32'h0, 1'b1, 32'h0},
      '{1'b0, 1'b0, 32'h1F00_0000, 4'hF, 32'h0, 1'b0, 32'h0},          // unmapped
      '{1'b1, 1'b0, 32'h0100_0000, 4'hF, 32'h0, 1'b0, 32'h0},
      '{1'b0, 1'b0, 32'h1FC0_0040, 4'hF, 32'h0, 1'b0, 32'h0}           // just past the rom
   };

   logic           clk, rst;
   logic [31:0]    data_addr, inst_addr;
   bus_pkg::word_t data_wdata, data_rdata, inst_rdata;
   bus_pkg::ben_t  data_wen;
   logic           data_ren, inst_ren, data_ack, inst_ack;

   bus_pkg::word_t main_mdl [mem_map_pkg::main_words];
   bus_pkg::word_t scr_mdl  [mem_map_pkg::scratch_words];
   bus_pkg::word_t rom_mdl  [mem_map_pkg::rom_words];
   bus_pkg::word_t last_data, last_inst;   // latest read result per channel
   bus_pkg::word_t seed;
   int             n_errors;

   clock_gen #(.period_ns(period_ns), .reset_cycles(4)) clocks (.clk_o(clk), .rst_o(rst));

   mem_controller uut (
      .clk, .rst,
      .data_addr_i(data_addr), .data_wdata_i(data_wdata), .data_ren_i(data_ren),
      .data_wen_i(data_wen), .data_ack_o(data_ack), .data_rdata_o(data_rdata),
      .inst_addr_i(inst_addr), .inst_ren_i(inst_ren), .inst_ack_o(inst_ack),
      .inst_rdata_o(inst_rdata)
   );

   task automatic report_error(input string msg);
      n_errors++;
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input bus_pkg::word_t got,
                             input bus_pkg::word_t exp);
      assert (got === exp) else
         report_error($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp));
   endtask

   function automatic bus_pkg::word_t next_random(input bus_pkg::word_t s);
      bus_pkg::word_t x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic mem_map_pkg::region_e region_of(input logic [31:0] addr);
      logic [31:0] phys;
      phys = addr & mem_map_pkg::seg_mask;   // segments mirror one space
      if (phys < mem_map_pkg::main_base + 4 * mem_map_pkg::main_words)   // main starts at 0
         return mem_map_pkg::REG_MAIN;
      if (phys >= mem_map_pkg::scratch_base &&
          phys < mem_map_pkg::scratch_base + 4 * mem_map_pkg::scratch_words)
         return mem_map_pkg::REG_SCRATCH;
      if (phys >= mem_map_pkg::rom_base &&
          phys < mem_map_pkg::rom_base + 4 * mem_map_pkg::rom_words)
         return mem_map_pkg::REG_ROM;
      return mem_map_pkg::REG_NONE;
   endfunction

   // regions are aligned to their size, so low address bits pick the word
   function automatic bus_pkg::word_t model_read(input logic [31:0] addr);
      case (region_of(addr))
         mem_map_pkg::REG_MAIN:    return main_mdl[addr[11:2]];
         mem_map_pkg::REG_SCRATCH: return scr_mdl[addr[9:2]];
         mem_map_pkg::REG_ROM:     return rom_mdl[addr[5:2]];
         default:                  return '0;
      endcase
   endfunction

   task automatic model_write(input logic [31:0] addr, input bus_pkg::ben_t ben,
                              input bus_pkg::word_t data);
      bus_pkg::word_t merged;
      merged = model_read(addr);
      for (int b = 0; b < 4; b++) begin
         if (ben[b])
            merged[8*b +: 8] = data[8*b +: 8];
      end
      if (region_of(addr) == mem_map_pkg::REG_MAIN)
         main_mdl[addr[11:2]] = merged;
      else if (region_of(addr) == mem_map_pkg::REG_SCRATCH)
         scr_mdl[addr[9:2]] = merged;   // rom and unmapped writes are dropped
   endtask

   // counts edges after the sampling edge until the ack is seen on a falling edge
   task automatic wait_ack(input logic is_inst, output int cycles);
      cycles = -1;
      do begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end while (!(is_inst ? inst_ack : data_ack));
   endtask

   task automatic wait_release();
      int edges;
      edges = 0;
      while (data_ack || inst_ack) begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      check_word("ack fall edges", edges, 1);   // first edge after the drop
   endtask

   // one four-phase access, entered and left on a falling edge
   task automatic run_access(input step_t s);
      int             cycles;
      bus_pkg::word_t exp;
      exp = s.from_model ? model_read(s.addr) : s.exp;
      if (s.inst) begin
         inst_addr = s.addr;
         inst_ren  = 1'b1;
      end else begin
         data_addr  = s.addr;
         data_wdata = s.wdata;
         data_ren   = !s.wr;
         data_wen   = s.wr ? s.ben : 4'h0;
      end
      wait_ack(s.inst, cycles);
      check_word(s.inst ? "inst_ack_o latency" : "data_ack_o latency", cycles, req_to_ack);
      if (s.wr) begin
         model_write(s.addr, s.ben, s.wdata);
         check_word("inst_rdata_o", inst_rdata, last_inst);
      end else if (s.inst) begin
         check_word("inst_rdata_o", inst_rdata, exp);
         check_word("data_rdata_o", data_rdata, last_data);
         last_inst = exp;
      end else begin
         check_word("data_rdata_o", data_rdata, exp);
         check_word("inst_rdata_o", inst_rdata, last_inst);   // other channel untouched
         last_data = exp;
      end
      inst_ren = 1'b0;
      data_ren = 1'b0;
      data_wen = 4'h0;
      wait_release();
   endtask

   // both ports raised on the same edge, data goes first
   task automatic race_ports();
      int             cycles;
      bus_pkg::word_t exp_data;
      bus_pkg::word_t exp_inst;
      exp_data  = model_read(32'h0000_0010);
      exp_inst  = model_read(32'h1FC0_0004);
      data_addr = 32'h0000_0010;
      data_ren  = 1'b1;
      inst_addr = 32'h1FC0_0004;
      inst_ren  = 1'b1;
      wait_ack(1'b0, cycles);
      check_word("data_ack_o latency", cycles, req_to_ack);
      check_word("inst_ack_o", inst_ack, 0);
      check_word("data_rdata_o", data_rdata, exp_data);
      data_ren = 1'b0;
      wait_release();
      wait_ack(1'b1, cycles);   // inst request held all along
      check_word("inst_ack_o latency", cycles, req_to_ack);
      check_word("inst_rdata_o", inst_rdata, exp_inst);
      check_word("data_rdata_o", data_rdata, exp_data);
      inst_ren = 1'b0;
      wait_release();
   endtask

   always @(negedge clk) begin
      if (!rst)
         assert (!(data_ack && inst_ack)) else
            report_error("data and instruction acks are high at the same time");
   end

   initial begin
      #(timeout_cyc * period_ns);
      $display("timeout: the accesses did not finish within %0d cycles", timeout_cyc);
      $display("tests failed");
      $fatal(1);
   end

   initial begin
      step_t s;
      n_errors   = 0;
      data_addr  = '0;
      data_wdata = '0;
      data_ren   = 1'b0;
      data_wen   = 4'h0;
      inst_addr  = '0;
      inst_ren   = 1'b0;
      last_data  = '0;   // rdata latches clear on reset
      last_inst  = '0;
      seed       = 32'h7016;
      $readmemh("hdl/boot_rom.hex", rom_mdl);
      @(negedge rst);
      @(negedge clk);

      // random contents for the first words of both RAMs
      for (int k = 0; k < fill_words; k++) begin
         seed = next_random(seed);
         s    = '{1'b0, 1'b1, mem_map_pkg::main_base + 4 * k, 4'hF, seed, 1'b0, 32'h0};
         run_access(s);
         seed = next_random(seed);
         s    = '{1'b0, 1'b1, mem_map_pkg::scratch_base + 4 * k, 4'hF, seed, 1'b0, 32'h0};
         run_access(s);
      end

      for (int i = 0; i < n_steps; i++)
         run_access(steps[i]);

      race_ports();

      if (n_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
